// File: compile.f
rtl/aes_ctrl_pkg.sv
rtl/aes_start_delay.sv
rtl/aes_sp2v_chk.sv
rtl/aes_ctrl_fsm.sv
rtl/aes_ctrl_combine.sv
rtl/aes_ctrl.sv
verif/tb_aes_ctrl.sv

// File: rtl/aes_ctrl.sv
// Cipher engine main control with a multi-rail FSM, sparse core handshake and status
`timescale 1ns/1ps

module aes_ctrl
  import aes_ctrl_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  reg_evt_t reg_evt_i,           // Data register write and read strobes
  input  logic     manual_operation_i,
  input  logic     start_i,
  input  sp2v_e    cipher_in_ready_i,
  input  sp2v_e    cipher_out_valid_i,
  input  logic     alert_fatal_i,
  output sp2v_e    cipher_in_valid_o,
  output sp2v_e    cipher_out_ready_o,
  output sp2v_e    data_out_we_o,
  output status_t  status_o,
  output logic     alert_o
);

  logic                      start_trigger;
  logic                      in_ready;
  logic                      out_valid;
  logic                      enc_err;
  logic                      rail_err;
  rail_out_t [Sp2VWidth-1:0] rails;

  aes_start_delay u_start_delay (
    .clk_i           ( clk_i         ),
    .rst_ni          ( rst_ni        ),
    .start_i         ( start_i       ),
    .start_trigger_o ( start_trigger )
  );

  aes_sp2v_chk u_sp2v_chk (
    .clk_i       ( clk_i              ),
    .rst_ni      ( rst_ni             ),
    .in_ready_i  ( cipher_in_ready_i  ),
    .out_valid_i ( cipher_out_valid_i ),
    .in_ready_o  ( in_ready           ),
    .out_valid_o ( out_valid          ),
    .err_o       ( enc_err            )
  );

  //////////////////////////////////////////////////////////////////////
  // One FSM rail per encoded bit
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_fsm
    aes_ctrl_fsm #(
      .RailHigh ( SP2V_LOGIC_HIGH[i] )
    ) u_fsm (
      .clk_i              ( clk_i              ),
      .rst_ni             ( rst_ni             ),
      .reg_evt_i          ( reg_evt_i          ),
      .manual_operation_i ( manual_operation_i ),
      .start_trigger_i    ( start_trigger      ),
      .in_ready_i         ( in_ready           ),
      .out_valid_i        ( out_valid          ),
      .enc_err_i          ( enc_err            ),
      .rail_err_i         ( rail_err           ), // From combiner
      .alert_fatal_i      ( alert_fatal_i      ),
      .rail_o             ( rails[i]           )
    );
  end

  aes_ctrl_combine u_combine (
    .rails_i            ( rails              ),
    .cipher_in_valid_o  ( cipher_in_valid_o  ),
    .cipher_out_ready_o ( cipher_out_ready_o ),
    .data_out_we_o      ( data_out_we_o      ),
    .status_o           ( status_o           ),
    .alert_o            ( alert_o            ),
    .rail_err_o         ( rail_err           )
  );

endmodule

// File: rtl/aes_ctrl_combine.sv
// Rail combiner that merges rail outputs and flags any disagreement between rails
`timescale 1ns/1ps

module aes_ctrl_combine
  import aes_ctrl_pkg::*;
(
  input  rail_out_t [Sp2VWidth-1:0] rails_i,
  output sp2v_e                     cipher_in_valid_o,
  output sp2v_e                     cipher_out_ready_o,
  output sp2v_e                     data_out_we_o,
  output status_t                   status_o,
  output logic                      alert_o,
  output logic                      rail_err_o
);

  logic      [Sp2VWidth-1:0] sp_in_valid;
  logic      [Sp2VWidth-1:0] sp_out_ready;
  logic      [Sp2VWidth-1:0] sp_out_we;
  rail_out_t [Sp2VWidth-1:0] dec;  // Rail outputs back in positive logic

  for (genvar i = 0; i < Sp2VWidth; i++) begin : gen_rail
    assign sp_in_valid[i]  = rails_i[i].cipher_in_valid;
    assign sp_out_ready[i] = rails_i[i].cipher_out_ready;
    assign sp_out_we[i]    = rails_i[i].data_out_we;

    assign dec[i].cipher_in_valid  = rails_i[i].cipher_in_valid  ~^ SP2V_LOGIC_HIGH[i];
    assign dec[i].cipher_out_ready = rails_i[i].cipher_out_ready ~^ SP2V_LOGIC_HIGH[i];
    assign dec[i].data_out_we      = rails_i[i].data_out_we      ~^ SP2V_LOGIC_HIGH[i];
    assign dec[i].alert            = rails_i[i].alert;
    assign dec[i].status           = rails_i[i].status;
  end

  // Each rail owns one bit of the encoded word
  assign cipher_in_valid_o  = sp2v_e'(sp_in_valid);
  assign cipher_out_ready_o = sp2v_e'(sp_out_ready);
  assign data_out_we_o      = sp2v_e'(sp_out_we);

  always_comb begin
    status_o   = '1;
    alert_o    = 1'b0;
    rail_err_o = 1'b0;
    for (int i = 0; i < Sp2VWidth; i++) begin
      status_o = status_o & rails_i[i].status;  // All rails must agree to raise a level
      alert_o  = alert_o | rails_i[i].alert;    // One rail is enough
      if (dec[i] != dec[0]) begin
        rail_err_o = 1'b1;
      end
    end
  end

endmodule

// File: rtl/aes_ctrl_fsm.sv
// Single-bit rail of the main control FSM that drives one bit of every encoded output
`timescale 1ns/1ps

module aes_ctrl_fsm
  import aes_ctrl_pkg::*;
#(
  parameter bit RailHigh = 1'b1  // Polarity of this rail's encoded bits
) (
  input  logic      clk_i,
  input  logic      rst_ni,
  input  reg_evt_t  reg_evt_i,
  input  logic      manual_operation_i,
  input  logic      start_trigger_i,
  input  logic      in_ready_i,
  input  logic      out_valid_i,
  input  logic      enc_err_i,
  input  logic      rail_err_i,
  input  logic      alert_fatal_i,
  output rail_out_t rail_o
);

  ctrl_state_e            state_d, state_q;
  ctrl_state_e            state_next;                // Transition before any fault
  logic [NumRegsData-1:0] in_mask_d, in_mask_q;    // Input registers written
  logic [NumRegsData-1:0] out_mask_d, out_mask_q;  // Output registers read
  logic                   output_valid_d, output_valid_q;
  logic                   output_lost_d, output_lost_q;
  logic                   in_full;
  logic                   start_ok;
  logic                   in_valid;
  logic                   out_ready;
  logic                   out_we;

  // Includes a write in the current cycle
  assign in_full  = &(in_mask_q | reg_evt_i.data_in_qe);
  assign start_ok = in_full && (!manual_operation_i || start_trigger_i);

  always_comb begin
    state_next = state_q;
    in_mask_d  = in_mask_q;
    in_valid   = 1'b0;
    out_ready  = 1'b0;
    out_we     = 1'b0;

    case (state_q)
      IDLE: begin
        in_mask_d  = in_mask_q | reg_evt_i.data_in_qe;
        state_next = LOAD;
      end

      LOAD: begin
        in_mask_d = in_mask_q | reg_evt_i.data_in_qe;
        if (start_ok) begin
          in_mask_d  = '0;  // Fresh set of writes for the next block
          state_next = START;
        end
      end

      START: begin
        in_valid = 1'b1;
        if (in_ready_i) begin
          state_next = FINISH;  // Core took the input
        end
      end

      FINISH: begin
        out_ready = 1'b1;
        if (out_valid_i) begin
          out_we     = 1'b1;
          state_next = IDLE;
        end
      end

      ERROR: begin
        state_next = ERROR;
      end

      default: state_next = ERROR;  // Corrupted state code
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // ERROR
  //////////////////////////////////////////////////////////////////////

  // Any fault overrides the transition above and only reset leaves ERROR
  assign state_d = (enc_err_i || rail_err_i || alert_fatal_i) ? ERROR : state_next;

  // Output status tracking
  always_comb begin
    out_mask_d     = out_mask_q | reg_evt_i.data_out_re;
    output_valid_d = output_valid_q;
    output_lost_d  = output_lost_q;
    if (out_we) begin
      out_mask_d     = '0;
      output_valid_d = 1'b1;
      output_lost_d  = output_valid_q;  // Previous result never fully read
    end else if (output_valid_q && (&out_mask_d)) begin
      output_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q        <= IDLE;
      in_mask_q      <= '0;
      out_mask_q     <= '0;
      output_valid_q <= 1'b0;
      output_lost_q  <= 1'b0;
    end else begin
      state_q        <= state_d;
      in_mask_q      <= in_mask_d;
      out_mask_q     <= out_mask_d;
      output_valid_q <= output_valid_d;
      output_lost_q  <= output_lost_d;
    end
  end

  // Encoded bits in this rail's polarity
  assign rail_o.cipher_in_valid  = RailHigh ? in_valid  : ~in_valid;
  assign rail_o.cipher_out_ready = RailHigh ? out_ready : ~out_ready;
  assign rail_o.data_out_we      = RailHigh ? out_we    : ~out_we;

  assign rail_o.alert                = (state_q == ERROR);
  assign rail_o.status.idle          = (state_q == IDLE) ||
                                       ((state_q == LOAD) && (in_mask_q == '0));
  assign rail_o.status.input_ready   = (state_q == IDLE) || (state_q == LOAD);
  assign rail_o.status.output_valid  = output_valid_q && (state_q != ERROR);
  assign rail_o.status.output_lost   = output_lost_q && (state_q != ERROR);

  err_terminal_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_q == ERROR) |=> (state_q == ERROR));

endmodule

// File: rtl/aes_ctrl_pkg.sv
// Cipher engine control package with sparse encodings, sizes, FSM states and shared structs

package aes_ctrl_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sparse two-value encoding
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned Sp2VWidth = 3;  // Also the number of FSM rails

  typedef enum logic [Sp2VWidth-1:0] {
    SP2V_HIGH = 3'b011,
    SP2V_LOW  = 3'b100
  } sp2v_e;

  // Per-bit polarity of the encoding where 1 means an active high rail
  localparam logic [Sp2VWidth-1:0] SP2V_LOGIC_HIGH = SP2V_HIGH;

  localparam int unsigned NumSp2VIn = 2;  // cipher_in_ready, cipher_out_valid

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned NumRegsData   = 4;
  localparam int unsigned StartDelay    = 3;  // Cycles of start_i before the trigger
  localparam int unsigned StartCntWidth = $clog2(StartDelay + 1);

  // Five states at a minimum Hamming distance of 3 need six bits
  localparam int unsigned StateWidth = 6;

  typedef enum logic [StateWidth-1:0] {
    IDLE   = 6'b001110,
    LOAD   = 6'b110010,
    START  = 6'b011001,
    FINISH = 6'b100101,
    ERROR  = 6'b111111
  } ctrl_state_e;

  //////////////////////////////////////////////////////////////////////
  // Grouped signals
  //////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [NumRegsData-1:0] data_in_qe;   // Input data register written
    logic [NumRegsData-1:0] data_out_re;  // Output data register read
  } reg_evt_t;

  typedef struct packed {
    logic idle;
    logic input_ready;
    logic output_valid;
    logic output_lost;
  } status_t;

  // Outputs of one rail with encoded bits in that rail's polarity
  typedef struct packed {
    logic    cipher_in_valid;
    logic    cipher_out_ready;
    logic    data_out_we;
    logic    alert;
    status_t status;
  } rail_out_t;

endpackage

// File: rtl/aes_sp2v_chk.sv
// Sparse input checker that decodes the cipher core handshake bits and flags invalid codes
`timescale 1ns/1ps

module aes_sp2v_chk
  import aes_ctrl_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  input  sp2v_e in_ready_i,
  input  sp2v_e out_valid_i,
  output logic  in_ready_o,
  output logic  out_valid_o,
  output logic  err_o
);

  sp2v_e [NumSp2VIn-1:0] sig;
  logic  [NumSp2VIn-1:0] sig_high;
  logic  [NumSp2VIn-1:0] sig_err;

  assign sig[0] = in_ready_i;
  assign sig[1] = out_valid_i;

  // Anything but the two legal codes is an error and decodes as low
  for (genvar i = 0; i < NumSp2VIn; i++) begin : gen_chk
    assign sig_high[i] = (sig[i] == SP2V_HIGH);
    assign sig_err[i]  = (sig[i] != SP2V_HIGH) && (sig[i] != SP2V_LOW);
  end

  assign in_ready_o  = sig_high[0];
  assign out_valid_o = sig_high[1];
  assign err_o       = |sig_err;

  enc_err_w: assert property (@(posedge clk_i) disable iff (!rst_ni) !$rose(err_o))
    else $warning("Invalid sparse code on cipher core handshake");

endmodule

// File: rtl/aes_start_delay.sv
// Start delay that releases the manual start trigger once start has been held long enough
`timescale 1ns/1ps

module aes_start_delay
  import aes_ctrl_pkg::*;
(
  input  logic clk_i,
  input  logic rst_ni,
  input  logic start_i,
  output logic start_trigger_o
);

  logic [StartCntWidth-1:0] count_d, count_q;

  assign start_trigger_o = (count_q == StartCntWidth'(StartDelay));

  // Clear on low start and hold once the delay is reached
  assign count_d = !start_i        ? '0      :
                   start_trigger_o ? count_q : count_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  // Counter saturates at the delay instead of wrapping past it
  cnt_sat_a: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (start_trigger_o && start_i) |=> start_trigger_o);

endmodule

// File: run.sh
#!/bin/sh
# Builds the control block testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 \
  --top-module tb_aes_ctrl \
  --Mdir obj_dir \
  -o sim_tb_aes_ctrl \
  -f compile.f
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit "$status"
fi

./obj_dir/sim_tb_aes_ctrl
status=$?
if [ "$status" -ne 0 ]; then
  echo "Simulation ended with status $status"
  exit "$status"
fi
exit 0

// File: verif/tb_aes_ctrl.sv
// Testbench for the cipher engine main control with a table of cases and a cipher core model
`timescale 1ns/1ps

module tb_aes_ctrl
  import aes_ctrl_pkg::*;
();

  localparam int NumRows    = 6;
  localparam int MaxDelay   = 8;   // Longest core answer delay
  localparam int StartWin   = 10;  // Cycles allowed for a start to show up
  localparam int CycleLimit = NumRows * (5 + NumRegsData + 2 * MaxDelay + NumRegsData + 20) * 2;
  localparam logic [31:0] AllLow = 32'({SP2V_LOW, SP2V_LOW, SP2V_LOW});

  typedef struct {
    string      name;
    bit         manual;
    int         hold;        // Cycles of start_i in manual mode
    int         ops;         // Operations before the reads
    logic [2:0] ready_code;  // Code the core answers with
    bit         fatal;       // Pulse alert_fatal_i instead of ready
    bit         exp_alert;
    bit         exp_valid;
    bit         exp_lost;
    bit         exp_started;
  } row_t;

  logic     clk_i;
  logic     rst_ni;
  reg_evt_t reg_evt_i;
  logic     manual_operation_i;
  logic     start_i;
  sp2v_e    cipher_in_ready_i;
  sp2v_e    cipher_out_valid_i;
  logic     alert_fatal_i;
  sp2v_e    cipher_in_valid_o;
  sp2v_e    cipher_out_ready_o;
  sp2v_e    data_out_we_o;
  status_t  status_o;
  logic     alert_o;

  row_t        rows [NumRows];
  string       cur_name;
  int          we_seen     = 0;
  int          cycle_count = 0;
  int unsigned lcg_state   = 32'h0c36_e0d8;

  aes_ctrl i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CycleLimit) begin
      $display("Timeout after %0d cycles, the DUT never finished the tests", cycle_count);
      $display("Some tests failed");
      $fatal(1);
    end
  end

  // Output write cycles
  always @(negedge clk_i) begin
    if (rst_ni && (data_out_we_o == SP2V_HIGH)) begin
      we_seen <= we_seen + 1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  function automatic int unsigned next_random();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int core_delay();
    return 1 + int'((next_random() >> 16) % MaxDelay);  // 1 to 8 cycles
  endfunction

  function automatic logic [31:0] encoded_outputs();
    return 32'({cipher_in_valid_o, cipher_out_ready_o, data_out_we_o});
  endfunction

  task automatic check_val(input string what, input logic [31:0] exp_val,
                           input logic [31:0] act_val);
    if (exp_val !== act_val) begin
      $display("MISMATCH %s %s: expected %0h, actual %0h", cur_name, what, exp_val, act_val);
      $display("Some tests failed");
      $fatal(1);
    end
  endtask

  task automatic drive_reset_inputs(input bit manual);
    rst_ni             <= 1'b0;
    reg_evt_i          <= '0;
    manual_operation_i <= manual;
    start_i            <= 1'b0;
    cipher_in_ready_i  <= SP2V_LOW;
    cipher_out_valid_i <= SP2V_LOW;
    alert_fatal_i      <= 1'b0;
  endtask

  task automatic apply_reset(input bit manual);
    @(posedge clk_i);
    drive_reset_inputs(manual);
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    check_val("reset encoded outputs", AllLow, encoded_outputs());
    check_val("reset idle", 1, 32'(status_o.idle));
    check_val("reset input_ready", 1, 32'(status_o.input_ready));
    check_val("reset output_valid", 0, 32'(status_o.output_valid));
    check_val("reset output_lost", 0, 32'(status_o.output_lost));
    check_val("reset alert", 0, 32'(alert_o));
  endtask

  task automatic write_inputs();
    for (int i = 0; i < NumRegsData; i++) begin
      @(posedge clk_i);
      reg_evt_i.data_in_qe <= NumRegsData'(1) << i;
    end
    @(posedge clk_i);
    reg_evt_i.data_in_qe <= '0;
  endtask

  task automatic read_outputs();
    for (int i = 0; i < NumRegsData; i++) begin
      @(posedge clk_i);
      reg_evt_i.data_out_re <= NumRegsData'(1) << i;
      @(posedge clk_i);
      reg_evt_i.data_out_re <= '0;
      @(negedge clk_i);
      // Cleared only by the last of the four reads
      check_val("output_valid during reads", (i == NumRegsData - 1) ? 0 : 1,
                32'(status_o.output_valid));
    end
  endtask

  task automatic pulse_start(input int hold);
    @(posedge clk_i);
    start_i <= 1'b1;
    repeat (hold) @(posedge clk_i);
    start_i <= 1'b0;
  endtask

  task automatic wait_start(output bit seen);
    seen = 1'b0;
    for (int i = 0; i < StartWin && !seen; i++) begin
      @(negedge clk_i);
      seen = (cipher_in_valid_o == SP2V_HIGH);
    end
  endtask

  // Cipher core model that answers ready and then valid after random delays
  task automatic run_core(input row_t row);
    repeat (core_delay()) @(posedge clk_i);
    if (row.fatal) begin
      alert_fatal_i <= 1'b1;
      @(posedge clk_i);
      alert_fatal_i <= 1'b0;
    end else begin
      cipher_in_ready_i <= sp2v_e'(row.ready_code);
      @(posedge clk_i);
      cipher_in_ready_i <= SP2V_LOW;
      if (row.ready_code == SP2V_HIGH) begin
        do @(negedge clk_i); while (cipher_out_ready_o != SP2V_HIGH);
        repeat (core_delay()) @(posedge clk_i);
        cipher_out_valid_i <= SP2V_HIGH;
        @(posedge clk_i);
        cipher_out_valid_i <= SP2V_LOW;
      end
    end
    @(negedge clk_i);
  endtask

  task automatic check_terminal();
    // Core keeps answering so an FSM that left ERROR would still write
    @(posedge clk_i);
    cipher_in_ready_i  <= SP2V_HIGH;
    cipher_out_valid_i <= SP2V_HIGH;
    repeat (4) begin
      @(negedge clk_i);
      check_val("alert held", 1, 32'(alert_o));
      check_val("encoded outputs in error", AllLow, encoded_outputs());
      check_val("status in error", 0, 32'(status_o));
    end
    @(posedge clk_i);
    cipher_in_ready_i  <= SP2V_LOW;
    cipher_out_valid_i <= SP2V_LOW;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Table rows
  //////////////////////////////////////////////////////////////////////

  task automatic run_row(input row_t row);
    bit seen;
    bit started;
    int we_base;
    cur_name = row.name;
    apply_reset(row.manual);
    we_base = we_seen;
    started = 1'b0;
    for (int op = 0; op < row.ops; op++) begin
      write_inputs();
      if (row.manual) begin
        repeat (3) begin
          @(negedge clk_i);
          check_val("no start on writes", 32'(SP2V_LOW), 32'(cipher_in_valid_o));
        end
        pulse_start(row.hold);
      end
      wait_start(seen);
      if (!seen) begin
        break;
      end
      started = 1'b1;
      run_core(row);
      if (row.exp_alert) begin
        break;
      end
    end
    check_val("started", 32'(row.exp_started), 32'(started));
    check_val("alert", 32'(row.exp_alert), 32'(alert_o));
    check_val("output_valid", 32'(row.exp_valid), 32'(status_o.output_valid));
    check_val("output_lost", 32'(row.exp_lost), 32'(status_o.output_lost));
    if (row.exp_alert) begin
      check_terminal();
    end else if (row.exp_valid) begin
      read_outputs();
      check_val("output_lost after reads", 32'(row.exp_lost), 32'(status_o.output_lost));
    end
    // One write cycle per finished operation
    check_val("data_out_we cycles", (row.exp_started && !row.exp_alert) ? row.ops : 0,
              we_seen - we_base);
  endtask

  initial begin
    drive_reset_inputs(1'b0);
    // name, manual, hold, ops, ready code, fatal, alert, valid, lost, started
    rows[0] = '{"auto_single",  1'b0, 0,              1, SP2V_HIGH, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    rows[1] = '{"manual_short", 1'b1, StartDelay - 1, 1, SP2V_HIGH, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
    rows[2] = '{"manual_full",  1'b1, StartDelay,     1, SP2V_HIGH, 1'b0, 1'b0, 1'b1, 1'b0, 1'b1};
    rows[3] = '{"output_lost",  1'b0, 0,              2, SP2V_HIGH, 1'b0, 1'b0, 1'b1, 1'b1, 1'b1};
    rows[4] = '{"bad_ready",    1'b0, 0,              1, 3'b111,    1'b0, 1'b1, 1'b0, 1'b0, 1'b1};
    rows[5] = '{"fatal_alert",  1'b0, 0,              1, SP2V_HIGH, 1'b1, 1'b1, 1'b0, 1'b0, 1'b1};
    for (int r = 0; r < NumRows; r++) begin
      run_row(rows[r]);
    end
    $display("All tests passed");
    $finish;
  end

endmodule
